/* verilog/exec_cfg.svh */
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Architectural registers, x0 reads as zero
`define EXEC_NUM_REGS 32

// Instruction buffer entries
`define EXEC_IBUF_DEPTH 16

// APB address bits
`define EXEC_APB_AW 8

`endif

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } instr_i_t;

    // Branch offset bits are scattered over the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } instr_b_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_b_t b;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_IMM
    } alu_op_e;

endpackage

/* verilog/exec_ctrl_pkg.sv */
package exec_ctrl_pkg;

    import rv_isa_pkg::*;

    // Decode to execute pipeline record
    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm;
        logic        use_imm;
        alu_op_e     alu_op;
        logic        we;
        logic        branch;
        logic [2:0]  funct3;
    } dec_rec_t;

    typedef enum logic [1:0] {REGFILE, FROM_EX, FROM_WB} fwd_sel_e;

    typedef enum logic [1:0] {IDLE, RUN, DRAIN} issue_state_e;

endpackage

/* verilog/result_if.sv */
`timescale 1ns/1ns

// Result leaving a pipeline register
interface result_if;
    logic        valid;
    logic [4:0]  rd;
    logic        we;
    logic [31:0] data;
    logic        taken;

    modport producer (output valid, rd, we, data, taken);
    modport consumer (input valid, rd, we, data, taken);
endinterface

/* verilog/apb_regs.sv */
`timescale 1ns/1ns
`include "exec_cfg.svh"

module apb_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`EXEC_APB_AW-1:0] paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  logic                    busy,
    output logic                    start,
    input  logic                    pop,
    output logic                    not_empty,
    output logic [31:0]             head_instr,
    output logic [4:0]              rf_addr,
    input  logic [31:0]             rf_data,
    input  logic [31:0]             retired,
    input  logic [31:0]             taken_cnt
);
    localparam int DEPTH = `EXEC_IBUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [31:0]      ibuf [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             access;
    logic             full;
    logic             push;
    logic             sel_ctrl;
    logic             sel_status;
    logic             sel_ibuf;
    logic             sel_retired;
    logic             sel_taken;
    logic             sel_rf;

    // Zero wait states, transfer completes in the access phase
    assign pready = 1'b1;
    assign access = psel && penable;

    assign sel_ctrl    = paddr == 'h00;
    assign sel_status  = paddr == 'h04;
    assign sel_ibuf    = paddr == 'h08;
    assign sel_retired = paddr == 'h0C;
    assign sel_taken   = paddr == 'h10;
    // Register window 0x80 to 0xFC
    assign sel_rf      = paddr[`EXEC_APB_AW-1] && paddr[1:0] == 2'b00;
    assign rf_addr     = paddr[6:2];

    assign full       = count == CNT_W'(DEPTH);
    assign not_empty  = count != '0;
    assign head_instr = ibuf[head];

    assign start = access && pwrite && sel_ctrl && pwdata[0] && !busy;
    assign push  = access && pwrite && sel_ibuf && !busy && !full;

    always_comb begin
        pslverr = 1'b0;
        if (access) begin
            if (!(sel_ctrl || sel_status || sel_ibuf || sel_retired || sel_taken || sel_rf)) begin
                pslverr = 1'b1;
            end else if (pwrite && sel_ibuf && (busy || full)) begin
                pslverr = 1'b1;
            end else if (pwrite && sel_ctrl && pwdata[0] && busy) begin
                pslverr = 1'b1;
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (sel_ctrl) begin
                prdata = {31'b0, busy};
            end else if (sel_status) begin
                prdata = {{(24 - CNT_W){1'b0}}, count, 7'b0, busy};
            end else if (sel_retired) begin
                prdata = retired;
            end else if (sel_taken) begin
                prdata = taken_cnt;
            end else if (sel_rf) begin
                prdata = rf_data;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            ibuf[tail] <= pwdata;
        end
    end

    // Issue side must only pop a loaded entry
    pop_not_empty_a: assert property (@(posedge clk) disable iff (!rst_n) pop |-> not_empty);

endmodule

/* verilog/issue_fsm.sv */
`timescale 1ns/1ns

module issue_fsm import exec_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic       not_empty,
    output logic       pop,
    output logic       busy,
    output logic       clear_counts,
    input  logic       dec_valid,
    result_if.consumer ex_res,
    result_if.consumer wb_res
);
    issue_state_e state;
    issue_state_e state_nxt;
    logic         pipe_empty;

    assign pipe_empty = !dec_valid && !ex_res.valid && !wb_res.valid;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = RUN;
                end
            end
            RUN: begin
                if (!not_empty) begin
                    state_nxt = DRAIN;
                end
            end
            DRAIN: begin
                if (pipe_empty) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign busy         = state != IDLE;
    assign pop          = state == RUN && not_empty;
    // Counts restart with each run
    assign clear_counts = state == IDLE && start;

    // Nothing in flight while no run is active
    idle_pipe_empty_a: assert property (@(posedge clk) disable iff (!rst_n)
        state == IDLE |-> pipe_empty);

endmodule

/* verilog/retire_counter.sv */
`timescale 1ns/1ns

module retire_counter (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear_counts,
    result_if.consumer  wb_res,
    output logic [31:0] retired,
    output logic [31:0] taken_cnt
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retired   <= '0;
            taken_cnt <= '0;
        end else if (clear_counts) begin
            retired   <= '0;
            taken_cnt <= '0;
        end else if (wb_res.valid) begin
            retired <= retired + 32'd1;
            if (wb_res.taken) begin
                taken_cnt <= taken_cnt + 32'd1;
            end
        end
    end

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ns
`include "exec_cfg.svh"

module decode_stage import rv_isa_pkg::*, exec_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        issue_valid,
    input  instr_u      instr,
    result_if.consumer  wb_res,
    input  logic [4:0]  rf_addr,
    output logic [31:0] rf_data,
    output dec_rec_t    dec
);
    localparam int NUM_REGS = `EXEC_NUM_REGS;

    logic [31:0] regs [NUM_REGS];
    logic        rf_we;
    logic        alt;
    dec_rec_t    dec_nxt;

    assign rf_we = wb_res.valid && wb_res.we;

    // Same-cycle writeback is visible to the read
    function automatic logic [31:0] rf_read(input logic [4:0] addr);
        logic [31:0] val;
        if (addr == 5'd0) begin
            val = '0;
        end else if (rf_we && wb_res.rd == addr) begin
            val = wb_res.data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic alt_op);
        alu_op_e op;
        case (funct3)
            3'b000:  op = alt_op ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt_op ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we) begin
            regs[wb_res.rd] <= wb_res.data;
        end
    end

    always_comb begin
        rf_data = rf_read(rf_addr);
    end

    always_comb begin
        // Bit 30 selects SUB, and SRA for both shift forms
        alt = instr.r.funct7[5] && (instr.r.opcode == OPC_OP || instr.r.funct3 == 3'b101);

        dec_nxt        = '0;
        dec_nxt.valid  = issue_valid;
        dec_nxt.rd     = instr.r.rd;
        dec_nxt.rs1    = instr.r.rs1;
        dec_nxt.rs2    = instr.r.rs2;
        dec_nxt.funct3 = instr.r.funct3;
        dec_nxt.imm    = {{20{instr.i.imm[11]}}, instr.i.imm};
        dec_nxt.alu_op = alu_decode(instr.r.funct3, alt);

        case (instr.r.opcode)
            OPC_OP: begin
                dec_nxt.we = 1'b1;
            end
            OPC_OP_IMM: begin
                dec_nxt.we      = 1'b1;
                dec_nxt.use_imm = 1'b1;
            end
            OPC_LUI: begin
                dec_nxt.we      = 1'b1;
                dec_nxt.use_imm = 1'b1;
                dec_nxt.alu_op  = ALU_PASS_IMM;
                // Upper immediate spans the I-layout imm, rs1 and funct3 fields
                dec_nxt.imm     = {instr.i.imm, instr.i.rs1, instr.i.funct3, 12'b0};
            end
            OPC_BRANCH: begin
                dec_nxt.branch = 1'b1;
                dec_nxt.imm    = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
                                  instr.b.imm4_1, 1'b0};
            end
            default: begin
                dec_nxt.we = 1'b0;
            end
        endcase

        // x0 is never a destination
        if (dec_nxt.rd == 5'd0) begin
            dec_nxt.we = 1'b0;
        end

        dec_nxt.rs1_val = rf_read(dec_nxt.rs1);
        dec_nxt.rs2_val = rf_read(dec_nxt.rs2);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec <= '0;
        end else begin
            dec <= dec_nxt;
        end
    end

    // Write enable for x0 is dropped at decode, two stages upstream
    x0_never_written_a: assert property (@(posedge clk) disable iff (!rst_n)
        rf_we |-> wb_res.rd != 5'd0);

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage import rv_isa_pkg::*, exec_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  dec_rec_t   dec,
    result_if.producer ex_res,
    result_if.producer wb_res
);
    fwd_sel_e    fwd_a;
    fwd_sel_e    fwd_b;
    logic [31:0] op_a;
    logic [31:0] op_b_reg;
    logic [31:0] op_b;
    logic [31:0] alu_out;
    logic        cmp_true;

    // Youngest producer wins
    function automatic fwd_sel_e fwd_pick(input logic [4:0] rs);
        fwd_sel_e sel;
        if (rs != 5'd0 && ex_res.valid && ex_res.we && ex_res.rd == rs) begin
            sel = FROM_EX;
        end else if (rs != 5'd0 && wb_res.valid && wb_res.we && wb_res.rd == rs) begin
            sel = FROM_WB;
        end else begin
            sel = REGFILE;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = fwd_pick(dec.rs1);
        fwd_b = fwd_pick(dec.rs2);

        case (fwd_a)
            FROM_EX: op_a = ex_res.data;
            FROM_WB: op_a = wb_res.data;
            default: op_a = dec.rs1_val;
        endcase

        case (fwd_b)
            FROM_EX: op_b_reg = ex_res.data;
            FROM_WB: op_b_reg = wb_res.data;
            default: op_b_reg = dec.rs2_val;
        endcase

        op_b = dec.use_imm ? dec.imm : op_b_reg;
    end

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:      alu_out = op_a + op_b;
            ALU_SUB:      alu_out = op_a - op_b;
            ALU_SLL:      alu_out = op_a << op_b[4:0];
            ALU_SLT:      alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:     alu_out = {31'b0, op_a < op_b};
            ALU_XOR:      alu_out = op_a ^ op_b;
            ALU_SRL:      alu_out = op_a >> op_b[4:0];
            ALU_SRA:      alu_out = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_OR:       alu_out = op_a | op_b;
            ALU_AND:      alu_out = op_a & op_b;
            ALU_PASS_IMM: alu_out = op_b;
            default:      alu_out = '0;
        endcase
    end

    // Branch compare on the register operands only
    always_comb begin
        case (dec.funct3)
            3'b000:  cmp_true = op_a == op_b_reg;
            3'b001:  cmp_true = op_a != op_b_reg;
            3'b100:  cmp_true = $signed(op_a) < $signed(op_b_reg);
            3'b101:  cmp_true = $signed(op_a) >= $signed(op_b_reg);
            default: cmp_true = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_res.valid <= 1'b0;
            ex_res.we    <= 1'b0;
            ex_res.taken <= 1'b0;
            wb_res.valid <= 1'b0;
            wb_res.we    <= 1'b0;
            wb_res.taken <= 1'b0;
        end else begin
            ex_res.valid <= dec.valid;
            ex_res.we    <= dec.valid && dec.we;
            ex_res.taken <= dec.valid && dec.branch && cmp_true;
            wb_res.valid <= ex_res.valid;
            wb_res.we    <= ex_res.we;
            wb_res.taken <= ex_res.taken;
        end
    end

    always_ff @(posedge clk) begin
        ex_res.rd   <= dec.rd;
        ex_res.data <= alu_out;
        wb_res.rd   <= ex_res.rd;
        wb_res.data <= ex_res.data;
    end

endmodule

/* verilog/exec_core.sv */
`timescale 1ns/1ns
`include "exec_cfg.svh"

module exec_core import exec_ctrl_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`EXEC_APB_AW-1:0] paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr
);
    logic        start;
    logic        pop;
    logic        not_empty;
    logic        busy;
    logic        clear_counts;
    logic [31:0] head_instr;
    logic [4:0]  rf_addr;
    logic [31:0] rf_data;
    logic [31:0] retired;
    logic [31:0] taken_cnt;
    dec_rec_t    dec;

    result_if ex_res_if ();
    result_if wb_res_if ();

    apb_regs apb_regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .busy       (busy),
        .start      (start),
        .pop        (pop),
        .not_empty  (not_empty),
        .head_instr (head_instr),
        .rf_addr    (rf_addr),
        .rf_data    (rf_data),
        .retired    (retired),
        .taken_cnt  (taken_cnt)
    );

    issue_fsm issue_fsm_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .not_empty    (not_empty),
        .pop          (pop),
        .busy         (busy),
        .clear_counts (clear_counts),
        .dec_valid    (dec.valid),
        .ex_res       (ex_res_if.consumer),
        .wb_res       (wb_res_if.consumer)
    );

    retire_counter retire_counter_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear_counts (clear_counts),
        .wb_res       (wb_res_if.consumer),
        .retired      (retired),
        .taken_cnt    (taken_cnt)
    );

    // Buffer head enters decode on each pop
    decode_stage decode_stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (pop),
        .instr       (head_instr),
        .wb_res      (wb_res_if.consumer),
        .rf_addr     (rf_addr),
        .rf_data     (rf_data),
        .dec         (dec)
    );

    execute_stage execute_stage_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .dec    (dec),
        .ex_res (ex_res_if.producer),
        .wb_res (wb_res_if.producer)
    );

endmodule

/* verification/exec_core_tb.sv */
`timescale 1ns/1ns
`include "exec_cfg.svh"

module exec_core_tb;
    localparam logic [`EXEC_APB_AW-1:0] A_CTRL    = 'h00;
    localparam logic [`EXEC_APB_AW-1:0] A_STATUS  = 'h04;
    localparam logic [`EXEC_APB_AW-1:0] A_IBUF    = 'h08;
    localparam logic [`EXEC_APB_AW-1:0] A_RETIRED = 'h0C;
    localparam logic [`EXEC_APB_AW-1:0] A_TAKEN   = 'h10;
    localparam int NUM_REGS   = `EXEC_NUM_REGS;
    localparam int IBUF_DEPTH = `EXEC_IBUF_DEPTH;
    localparam int IDLE_POLLS = 64;
    localparam int READY_WAIT = 8;

    logic                    clk;
    logic                    rst_n;
    logic [`EXEC_APB_AW-1:0] paddr;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic                    pready;
    logic                    pslverr;

    // Reference state
    logic [31:0] mregs [NUM_REGS];
    int          m_retired;
    int          m_taken;
    int          seed;
    logic [31:0] prog [$];

    exec_core dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    pready_high_a: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else begin
            $display("Error: pready is 0x0, expected 0x1");
            abort_run();
        end

    // Outside the access phase the slave drives nothing
    bus_quiet_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(psel && penable) |-> !pslverr && prdata == 32'h0)
        else begin
            $display("Error: prdata 0x%08h or pslverr 0x%0h set outside access phase",
                     prdata, pslverr);
            abort_run();
        end

    task automatic apb_xfer(input logic wr, input logic [`EXEC_APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        int waits;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        waits = 0;
        @(negedge clk);
        while (!pready) begin
            waits++;
            if (waits > READY_WAIT) begin
                $display("APB transfer saw no pready within %0d cycles", READY_WAIT);
                abort_run();
            end
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input logic [`EXEC_APB_AW-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, addr, data, rdata, err);
        expect_value("pslverr", err, exp_err);
    endtask

    task automatic apb_read_check(input logic [`EXEC_APB_AW-1:0] addr, input string name,
                                  input logic [31:0] exp);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b0, addr, 32'h0, rdata, err);
        expect_value("pslverr", err, 1'b0);
        expect_value(name, rdata, exp);
    endtask

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'h37};
    endfunction

    // Offset of +8 puts a nonzero value in the rd field position
    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2);
        return {7'b0, rs2, rs1, f3, 5'b01000, 7'h63};
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] rnd;
        rnd = $random(seed);
        return 5'(1 + rnd[2:0]);
    endfunction

    function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0: begin
                if (alt) r = a - b;
                else r = a + b;
            end
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) r = $signed(a) >>> b[4:0];
                else r = a >> b[4:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic model_step(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic        wr;
        logic        tk;
        a   = mregs[w[19:15]];
        b   = mregs[w[24:20]];
        imm = {{20{w[31]}}, w[31:20]};
        res = 32'h0;
        wr  = 1'b1;
        tk  = 1'b0;
        case (w[6:0])
            7'h33: res = model_alu(w[14:12], w[30], a, b);
            7'h13: res = model_alu(w[14:12], w[30] && w[14:12] == 3'd5, a, imm);
            7'h37: res = {w[31:12], 12'h000};
            7'h63: begin
                wr = 1'b0;
                case (w[14:12])
                    3'd0: tk = a == b;
                    3'd1: tk = a != b;
                    3'd4: tk = $signed(a) < $signed(b);
                    3'd5: tk = $signed(a) >= $signed(b);
                    default: tk = 1'b0;
                endcase
            end
            default: wr = 1'b0;
        endcase
        if (wr && w[11:7] != 5'd0) begin
            mregs[w[11:7]] = res;
        end
        m_retired++;
        if (tk) begin
            m_taken++;
        end
    endtask

    // Loads one buffer's worth of the queued program
    task automatic push_chunk();
        logic [31:0] w;
        int          n;
        m_retired = 0;
        m_taken   = 0;
        n = 0;
        while (n < IBUF_DEPTH && prog.size() > 0) begin
            w = prog.pop_front();
            apb_write(A_IBUF, w, 1'b0);
            model_step(w);
            n++;
        end
    endtask

    task automatic start_run();
        logic [31:0] rdata;
        logic        err;
        apb_write(A_CTRL, 32'h1, 1'b0);
        apb_xfer(1'b0, A_STATUS, 32'h0, rdata, err);
        expect_value("STATUS.busy", rdata[0], 1'b1);
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        logic        err;
        int          polls;
        polls = 0;
        st    = 32'h1;
        while (st[0]) begin
            if (polls == IDLE_POLLS) begin
                $display("Run still busy after %0d status polls", polls);
                abort_run();
            end
            apb_xfer(1'b0, A_STATUS, 32'h0, st, err);
            expect_value("pslverr", err, 1'b0);
            polls++;
        end
        expect_value("STATUS", st, 32'h0);
    endtask

    task automatic check_counts();
        apb_read_check(A_RETIRED, "RETIRED", m_retired);
        apb_read_check(A_TAKEN, "TAKEN", m_taken);
    endtask

    task automatic check_regs();
        for (int n = 0; n < NUM_REGS; n++) begin
            apb_read_check(8'h80 + 8'(4 * n), $sformatf("x%0d", n), mregs[n]);
        end
    endtask

    task automatic run_program();
        while (prog.size() > 0) begin
            push_chunk();
            start_run();
            wait_idle();
            check_counts();
        end
        check_regs();
    endtask

    task automatic check_reset_values();
        apb_read_check(A_STATUS, "STATUS", 32'h0);
        apb_read_check(A_RETIRED, "RETIRED", 32'h0);
        apb_read_check(A_TAKEN, "TAKEN", 32'h0);
        apb_read_check(8'h80, "x0", 32'h0);
        apb_read_check(8'h84, "x1", 32'h0);
        apb_read_check(8'hC4, "x17", 32'h0);
        apb_read_check(8'hFC, "x31", 32'h0);
    endtask

    task automatic check_alu_ops();
        // {alternate bit, funct3} per operation
        logic [3:0]  r_ops [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hD, 4'h6, 4'h7};
        logic [3:0]  i_ops [8]  = '{4'h0, 4'h7, 4'h6, 4'h4, 4'h2, 4'h1, 4'h5, 4'hD};
        logic [31:0] rnd;
        logic [11:0] imm;
        for (int r = 1; r <= 8; r++) begin
            rnd = $random(seed);
            prog.push_back(lui_word(rnd[31:12], 5'(r)));
            prog.push_back(i_type_word(rnd[11:0], 5'(r), 3'd0, 5'(r)));
        end
        // Destination x0 must be ignored
        prog.push_back(i_type_word(12'h123, 5'd1, 3'd0, 5'd0));
        for (int k = 0; k < 10; k++) begin
            prog.push_back(r_type_word({1'b0, r_ops[k][3], 5'b0}, pick_reg(), pick_reg(),
                                       r_ops[k][2:0], 5'(9 + k)));
        end
        for (int k = 0; k < 8; k++) begin
            rnd = $random(seed);
            imm = rnd[11:0];
            if (i_ops[k][1:0] == 2'b01) begin
                imm = {1'b0, i_ops[k][3], 5'b0, rnd[4:0]};
            end
            prog.push_back(i_type_word(imm, pick_reg(), i_ops[k][2:0], 5'(19 + k)));
        end
        run_program();
    endtask

    // Dependencies at distance one, two, three and four
    task automatic check_forwarding();
        logic [31:0] rnd;
        rnd = $random(seed);
        prog.push_back(i_type_word(rnd[11:0], 5'd0, 3'd0, 5'd1));
        prog.push_back(r_type_word(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));
        prog.push_back(r_type_word(7'h20, 5'd1, 5'd2, 3'd0, 5'd3));
        prog.push_back(r_type_word(7'h00, 5'd1, 5'd3, 3'd4, 5'd4));
        prog.push_back(r_type_word(7'h00, 5'd1, 5'd4, 3'd6, 5'd5));
        prog.push_back(r_type_word(7'h00, 5'd5, 5'd5, 3'd0, 5'd6));
        prog.push_back(r_type_word(7'h00, 5'd4, 5'd6, 3'd1, 5'd7));
        prog.push_back(r_type_word(7'h20, 5'd0, 5'd7, 3'd0, 5'd7));
        prog.push_back(r_type_word(7'h00, 5'd7, 5'd0, 3'd0, 5'd8));
        run_program();
    endtask

    task automatic check_branches();
        prog.push_back(i_type_word(12'd5, 5'd0, 3'd0, 5'd10));
        prog.push_back(i_type_word(12'd5, 5'd0, 3'd0, 5'd11));
        prog.push_back(i_type_word(12'hFFD, 5'd0, 3'd0, 5'd12));
        prog.push_back(branch_word(3'd0, 5'd10, 5'd11));
        prog.push_back(branch_word(3'd0, 5'd10, 5'd12));
        prog.push_back(branch_word(3'd1, 5'd10, 5'd12));
        prog.push_back(branch_word(3'd1, 5'd10, 5'd11));
        prog.push_back(branch_word(3'd4, 5'd12, 5'd10));
        prog.push_back(branch_word(3'd4, 5'd10, 5'd12));
        prog.push_back(branch_word(3'd5, 5'd10, 5'd11));
        prog.push_back(branch_word(3'd5, 5'd12, 5'd10));
        // Compare operands forwarded from the previous instruction
        prog.push_back(i_type_word(12'd7, 5'd0, 3'd0, 5'd13));
        prog.push_back(branch_word(3'd0, 5'd13, 5'd13));
        run_program();
    endtask

    task automatic check_protocol_errors();
        logic [31:0] rdata;
        logic        err;
        for (int k = 0; k < IBUF_DEPTH; k++) begin
            prog.push_back(i_type_word(12'(k + 1), 5'(20 + (k + 7) % 8), 3'd0, 5'(20 + k % 8)));
        end
        push_chunk();
        apb_write(A_IBUF, i_type_word(12'h7FF, 5'd0, 3'd0, 5'd30), 1'b1);
        apb_read_check(A_STATUS, "STATUS", 32'(IBUF_DEPTH) << 8);
        apb_write(8'h14, 32'hDEAD_BEEF, 1'b1);
        apb_xfer(1'b0, 8'h40, 32'h0, rdata, err);
        expect_value("pslverr", err, 1'b1);
        apb_read_check(A_STATUS, "STATUS", 32'(IBUF_DEPTH) << 8);
        start_run();
        apb_write(A_IBUF, i_type_word(12'h7FF, 5'd0, 3'd0, 5'd30), 1'b1);
        apb_write(A_CTRL, 32'h1, 1'b1);
        wait_idle();
        check_counts();
        check_regs();
    endtask

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = 32'h0;
        seed    = 32'h69ab;
        m_retired = 0;
        m_taken   = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            mregs[i] = 32'h0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        check_reset_values();
        check_alu_ops();
        check_forwarding();
        check_branches();
        check_protocol_errors();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* exec_core.f */
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/exec_ctrl_pkg.sv
verilog/result_if.sv
verilog/apb_regs.sv
verilog/issue_fsm.sv
verilog/retire_counter.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/exec_core.sv
verification/exec_core_tb.sv

/* Bender.yml */
package:
  name: exec_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_isa_pkg.sv
      - verilog/exec_ctrl_pkg.sv
      - verilog/result_if.sv
      - verilog/apb_regs.sv
      - verilog/issue_fsm.sv
      - verilog/retire_counter.sv
      - verilog/decode_stage.sv
      - verilog/execute_stage.sv
      - verilog/exec_core.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/exec_core_tb.sv
